//--- verilog.f
verilog/rvIsaPkg.sv
verilog/pipePkg.sv
verilog/stageIf.sv
verilog/regFile.sv
verilog/hazardScoreboard.sv
verilog/decodeStage.sv
verilog/issueStage.sv
verilog/executeStage.sv
verilog/coreTop.sv
tests/tbChecker.sv
tests/tbTop.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then look for the failure line in the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f verilog.f --top-module tbTop -o tbSim > build.log 2>&1 ||
    { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tbSim > sim.log 2>&1
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0

//--- tests/tbTop.sv
`timescale 1ns/10ps

module tbTop import pipePkg::*; ();

    localparam int PROG_LEN = 400;
    localparam int WAIT_MAX = 50;    // cycles any single wait may take
    localparam int DRAIN_MAX = 200;

    logic                  clk;
    logic                  nrst;
    logic                  instrValid;
    logic [INSTR_W-1:0]    instrWord;
    logic                  instrReady;
    logic                  commitValid;
    logic [REG_ADDR_W-1:0] commitRd;
    logic [XLEN-1:0]       commitData;
    logic                  exactLatency;
    int                    valueErrors;
    int                    orderErrors;
    int                    pending;
    int                    resetErrors;
    int                    guard;

    coreTop i_coreTop (
        .clk         (clk),
        .nrst        (nrst),
        .instrValid  (instrValid),
        .instrWord   (instrWord),
        .instrReady  (instrReady),
        .commitValid (commitValid),
        .commitRd    (commitRd),
        .commitData  (commitData)
    );

    tbChecker i_tbChecker (
        .clk(clk), .nrst(nrst), .instrValid(instrValid), .instrWord(instrWord),
        .instrReady(instrReady), .commitValid(commitValid), .commitRd(commitRd),
        .commitData(commitData), .exactLatency(exactLatency), .valueErrors(valueErrors),
        .orderErrors(orderErrors), .pending(pending)
    );

    always #5 clk = ~clk;

    task automatic abortRun(input string what);
        $display("timeout: %s", what);
        $display("TESTS FAILED");
        $finish;
    endtask

    // present one word and hold it until the core takes it
    task automatic sendWord(input logic [31:0] word);
        int waited;
        waited     = 0;
        instrValid = 1'b1;
        instrWord  = word;
        while (!instrReady) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > WAIT_MAX) abortRun("instrReady stayed low, core never took the word");
        end
        @(posedge clk);
        #1;
        instrValid = 1'b0;
    endtask

    function automatic logic [31:0] randomWord();
        logic [2:0]  f3;
        logic [11:0] imm;
        int          kind;
        f3   = 3'($urandom_range(7, 0));
        imm  = 12'($urandom);
        kind = $urandom_range(15, 0);
        if (kind == 0) begin
            return {25'($urandom), 7'b0000011};   // load opcode is not supported
        end else if (kind < 4) begin
            return {20'($urandom), 2'b00, 3'($urandom_range(7, 0)), 7'b0110111};
        end else if (kind < 10) begin
            if (f3 == 3'd1) imm[11:5] = 7'h00;
            if (f3 == 3'd5) imm[11:5] = ($urandom_range(1, 0) != 0) ? 7'h20 : 7'h00;
            return {imm, 2'b00, 3'($urandom_range(7, 0)), f3, 2'b00,
                    3'($urandom_range(7, 0)), 7'b0010011};
        end
        return {1'b0, (f3 == 3'd0 || f3 == 3'd5) ? 1'($urandom_range(1, 0)) : 1'b0, 5'd0,
                2'b00, 3'($urandom_range(7, 0)), 2'b00, 3'($urandom_range(7, 0)), f3,
                2'b00, 3'($urandom_range(7, 0)), 7'b0110011};
    endfunction

    initial begin
        void'($urandom(91));
        clk          = 1'b0;
        nrst         = 1'b0;
        instrValid   = 1'b0;
        instrWord    = '0;
        exactLatency = 1'b0;
        resetErrors  = 0;
        repeat (3) @(posedge clk);
        #1 nrst = 1'b1;
        @(posedge clk);
        #1;
        if (instrReady !== 1'b1 || commitValid !== 1'b0) begin
            resetErrors++;
            $display("ERROR %0t: after reset instrReady=%b commitValid=%b", $time,
                     instrReady, commitValid);
        end
        // independent addi/lui from x0 never stall
        exactLatency = 1'b1;
        for (int i = 0; i < 24; i++) begin
            if (i % 3 == 2) sendWord({20'($urandom), 5'(i % 7 + 1), 7'b0110111});
            else sendWord({12'($urandom), 5'd0, 3'd0, 5'(i % 7 + 1), 7'b0010011});
        end
        exactLatency = 1'b0;
        sendWord({12'd7, 5'd0, 3'd0, 5'd5, 7'b0010011});        // addi x5, x0, 7
        sendWord({7'd0, 5'd5, 5'd5, 3'd0, 5'd6, 7'b0110011});   // add x6, x5, x5
        sendWord({12'd3, 5'd5, 3'd0, 5'd0, 7'b0010011});        // addi x0, x5, 3
        sendWord({7'd0, 5'd0, 5'd0, 3'd0, 5'd7, 7'b0110011});   // add x7, x0, x0
        for (int i = 0; i < PROG_LEN; i++) begin
            sendWord(randomWord());
            if ($urandom_range(3, 0) == 0) begin
                repeat ($urandom_range(3, 1)) @(posedge clk);
                #1;
            end
        end
        guard = 0;
        while (pending != 0) begin
            @(posedge clk);
            guard++;
            if (guard > DRAIN_MAX) abortRun("expected commits never arrived during drain");
        end
        repeat (10) @(posedge clk);   // any stray commit would show up here
        $display("errors: value %0d, order %0d, reset %0d, left %0d", valueErrors,
                 orderErrors, resetErrors, pending);
        if (valueErrors == 0 && orderErrors == 0 && resetErrors == 0 && pending == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tests/tbChecker.sv
`timescale 1ns/10ps

module tbChecker import pipePkg::*; (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  instrValid,
    input  logic [INSTR_W-1:0]    instrWord,
    input  logic                  instrReady,
    input  logic                  commitValid,
    input  logic [REG_ADDR_W-1:0] commitRd,
    input  logic [XLEN-1:0]       commitData,
    input  logic                  exactLatency,   // tbTop promises no hazards right now
    output int                    valueErrors,
    output int                    orderErrors,
    output int                    pending
);

    logic [XLEN-1:0]       model [NUM_REGS];   // architectural register state
    logic [REG_ADDR_W-1:0] expRd [$];
    logic [XLEN-1:0]       expData [$];
    int                    expCycle [$];
    bit                    expExact [$];
    int                    cycle;

    function automatic bit isLegal(input logic [31:0] word);
        return word[6:0] == 7'b0110011 || word[6:0] == 7'b0010011 || word[6:0] == 7'b0110111;
    endfunction

    // expected rd value straight from the RV32I rules
    function automatic logic [31:0] isaResult(input logic [31:0] word, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [31:0] src2;
        logic [4:0]  sh;
        logic        isOp;
        isOp = word[6:0] == 7'b0110011;
        if (word[6:0] == 7'b0110111) begin
            return {word[31:12], 12'h000};   // lui
        end
        src2 = isOp ? b : {{20{word[31]}}, word[31:20]};
        sh   = src2[4:0];
        case (word[14:12])
            3'd0:    return (isOp && word[30]) ? a - src2 : a + src2;
            3'd1:    return a << sh;
            3'd2:    return {31'd0, $signed(a) < $signed(src2)};
            3'd3:    return {31'd0, a < src2};
            3'd4:    return a ^ src2;
            3'd5:    return word[30] ? $unsigned($signed(a) >>> sh) : a >> sh;
            3'd6:    return a | src2;
            default: return a & src2;
        endcase
    endfunction

    initial begin
        valueErrors = 0;
        orderErrors = 0;
        pending     = 0;
        cycle       = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model[i] = '0;
        end
    end

    always @(posedge clk) cycle++;

    // everything settles between edges, so sample on the falling edge
    always @(negedge clk) begin
        logic [31:0]           res;
        logic [REG_ADDR_W-1:0] rd;
        if (nrst) begin
            if (commitValid) begin
                if (expRd.size() == 0) begin
                    orderErrors++;
                    $display("unexpected commit at %0t: nothing was waiting to retire", $time);
                end else begin
                    if (commitRd !== expRd[0] || commitData !== expData[0]) begin
                        valueErrors++;
                        $display("ERROR %0t: commit x%0d=%h, expected x%0d=%h", $time,
                                 commitRd, commitData, expRd[0], expData[0]);
                    end
                    if (expExact[0] && cycle - expCycle[0] != 3) begin
                        valueErrors++;
                        $display("ERROR %0t: latency %0d, expected 3", $time,
                                 cycle - expCycle[0]);
                    end
                    void'(expRd.pop_front());
                    void'(expData.pop_front());
                    void'(expCycle.pop_front());
                    void'(expExact.pop_front());
                end
            end
            if (instrValid && instrReady && isLegal(instrWord)) begin
                res = isaResult(instrWord, model[instrWord[19:15]], model[instrWord[24:20]]);
                rd  = instrWord[11:7];
                if (rd != 0) begin
                    model[rd] = res;   // x0 stays zero
                end
                expRd.push_back(rd);
                expData.push_back(res);
                expCycle.push_back(cycle);
                expExact.push_back(exactLatency);
            end
            pending = expRd.size();
        end
    end

endmodule

//--- verilog/coreTop.sv
`timescale 1ns/10ps

module coreTop import pipePkg::*; (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  instrValid,
    input  logic [INSTR_W-1:0]    instrWord,
    output logic                  instrReady,
    output logic                  commitValid,
    output logic [REG_ADDR_W-1:0] commitRd,
    output logic [XLEN-1:0]       commitData
);

    decodeIf  decBus ();
    executeIf exeBus ();

    // writeback, shared by regfile, scoreboard and commit port
    logic                  wbValid;
    logic [REG_ADDR_W-1:0] wbRd;
    logic [XLEN-1:0]       wbData;

    decodeStage i_decodeStage (
        .clk        (clk),
        .nrst       (nrst),
        .instrValid (instrValid),
        .instrWord  (instrWord),
        .instrReady (instrReady),
        .dec        (decBus.producer)
    );

    issueStage i_issueStage (
        .clk     (clk),
        .nrst    (nrst),
        .dec     (decBus.consumer),
        .exe     (exeBus.producer),
        .wbValid (wbValid),
        .wbRd    (wbRd),
        .wbData  (wbData)
    );

    executeStage i_executeStage (
        .clk     (clk),
        .nrst    (nrst),
        .exe     (exeBus.consumer),
        .wbValid (wbValid),
        .wbRd    (wbRd),
        .wbData  (wbData)
    );

    assign commitValid = wbValid;
    assign commitRd    = wbRd;     // 0 for writes to x0
    assign commitData  = wbData;

endmodule

//--- verilog/executeStage.sv
`timescale 1ns/10ps

module executeStage import rvIsaPkg::*, pipePkg::*; (
    input  logic                  clk,
    input  logic                  nrst,
    executeIf.consumer            exe,
    output logic                  wbValid,
    output logic [REG_ADDR_W-1:0] wbRd,
    output logic [XLEN-1:0]       wbData
);

    logic [XLEN-1:0]    aluResult;
    logic [SHAMT_W-1:0] shamt;

    assign shamt = exe.opB[SHAMT_W-1:0];   // low bits only

    always_comb begin
        case (exe.op)
            ADD:     aluResult = exe.opA + exe.opB;
            SUB:     aluResult = exe.opA - exe.opB;
            SLL:     aluResult = exe.opA << shamt;
            SLT:     aluResult = {{(XLEN-1){1'b0}}, $signed(exe.opA) < $signed(exe.opB)};
            SLTU:    aluResult = {{(XLEN-1){1'b0}}, exe.opA < exe.opB};
            XOR:     aluResult = exe.opA ^ exe.opB;
            SRL:     aluResult = exe.opA >> shamt;
            SRA:     aluResult = $unsigned($signed(exe.opA) >>> shamt);
            OR:      aluResult = exe.opA | exe.opB;
            AND:     aluResult = exe.opA & exe.opB;
            PASSB:   aluResult = exe.opB;   // lui
            default: aluResult = '0;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wbValid <= 1'b0;
            wbRd    <= '0;
        end else begin
            wbValid <= exe.valid;
            // rd 0 tells the regfile and scoreboard there is nothing to write
            wbRd    <= (exe.valid && exe.we) ? exe.rd : '0;
        end
    end

    always_ff @(posedge clk) begin
        wbData <= aluResult;
    end

endmodule

//--- verilog/issueStage.sv
`timescale 1ns/10ps

module issueStage import rvIsaPkg::*, pipePkg::*; (
    input  logic                  clk,
    input  logic                  nrst,
    decodeIf.consumer             dec,
    executeIf.producer            exe,
    input  logic                  wbValid,
    input  logic [REG_ADDR_W-1:0] wbRd,
    input  logic [XLEN-1:0]       wbData
);

    logic [XLEN-1:0] rdDataA;
    logic [XLEN-1:0] rdDataB;
    logic [XLEN-1:0] opBSel;
    logic            hazard;
    logic            issue;

    regFile i_regFile (
        .clk     (clk),
        .nrst    (nrst),
        .we      (wbValid),
        .wrAddr  (wbRd),
        .wrData  (wbData),
        .rdAddrA (dec.rs1),
        .rdAddrB (dec.rs2),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB)
    );

    hazardScoreboard i_hazardScoreboard (
        .clk      (clk),
        .nrst     (nrst),
        .setValid (issue && dec.we),
        .setRd    (dec.rd),
        .clrValid (wbValid),
        .clrRd    (wbRd),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .stall    (hazard)
    );

    assign dec.hold = dec.valid && hazard;
    assign issue    = dec.valid && !hazard;

    // operand b mux
    always_comb begin
        case (dec.bSel)
            REG:     opBSel = rdDataB;
            IMM:     opBSel = dec.imm;
            SHAMT:   opBSel = {{(XLEN-SHAMT_W){1'b0}}, dec.shamt};
            default: opBSel = rdDataB;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            exe.valid <= 1'b0;
            exe.we    <= 1'b0;
        end else begin
            exe.valid <= issue;            // bubble while stalled
            exe.we    <= issue && dec.we;
        end
    end

    always_ff @(posedge clk) begin
        exe.op  <= dec.op;
        exe.rd  <= dec.rd;
        exe.opA <= rdDataA;
        exe.opB <= opBSel;
    end

    // there is no forwarding, so nothing may issue while its source is still in execute
    noStaleRead: assert property (@(posedge clk) disable iff (!nrst)
        issue && exe.valid && exe.we |-> dec.rs1 != exe.rd &&
            (dec.bSel != REG || dec.rs2 != exe.rd));

endmodule

//--- verilog/decodeStage.sv
`timescale 1ns/10ps

module decodeStage import rvIsaPkg::*, pipePkg::*; (
    input  logic               clk,
    input  logic               nrst,
    input  logic               instrValid,
    input  logic [INSTR_W-1:0] instrWord,
    output logic               instrReady,
    decodeIf.producer          dec
);

    opcode_e               opcode;
    logic [2:0]            funct3;
    logic                  alt;
    logic                  legal;
    aluOp_e                opNext;
    bSel_e                 bSelNext;
    logic [XLEN-1:0]       immNext;
    logic [REG_ADDR_W-1:0] rdField;
    logic [REG_ADDR_W-1:0] rs1Next;
    logic [REG_ADDR_W-1:0] rs2Next;
    logic                  accept;

    // funct3 (plus the alt bit) to alu operation
    function automatic aluOp_e aluFromFunct3(input logic [2:0] f3, input logic altBit);
        aluOp_e res;
        case (f3)
            F3_ADD:  res = altBit ? SUB : ADD;
            F3_SLL:  res = SLL;
            F3_SLT:  res = SLT;
            F3_SLTU: res = SLTU;
            F3_XOR:  res = XOR;
            F3_SRL:  res = altBit ? SRA : SRL;
            F3_OR:   res = OR;
            F3_AND:  res = AND;
            default: res = ADD;
        endcase
        return res;
    endfunction

    assign opcode  = opcode_e'(instrWord[OPCODE_LSB +: OPCODE_W]);
    assign funct3  = instrWord[FUNCT3_LSB +: 3];
    assign alt     = instrWord[ALT_BIT];
    assign rdField = instrWord[RD_LSB +: REG_ADDR_W];

    assign instrReady = !dec.hold;
    assign accept     = instrValid && instrReady;

    always_comb begin
        legal    = 1'b1;
        opNext   = aluFromFunct3(funct3, alt);
        bSelNext = REG;
        immNext  = {{(XLEN-12){instrWord[SIGN_BIT]}}, instrWord[IMM_I_LSB +: 12]};
        rs1Next  = instrWord[RS1_LSB +: REG_ADDR_W];
        rs2Next  = instrWord[RS2_LSB +: REG_ADDR_W];
        case (opcode)
            OP: begin
                bSelNext = REG;
            end
            OP_IMM: begin
                // no subi, the alt bit only means sra here
                opNext   = aluFromFunct3(funct3, alt && funct3 == F3_SRL);
                bSelNext = (funct3 == F3_SLL || funct3 == F3_SRL) ? SHAMT : IMM;
                rs2Next  = '0;   // imm bits, not a source
            end
            LUI: begin
                opNext   = PASSB;
                bSelNext = IMM;
                immNext  = {instrWord[SIGN_BIT:IMM_U_LSB], {IMM_U_LSB{1'b0}}};
                rs1Next  = '0;
                rs2Next  = '0;
            end
            default: legal = 1'b0;   // becomes a bubble
        endcase
    end

    // control part of the stage register
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            dec.valid <= 1'b0;
            dec.we    <= 1'b0;
        end else if (!dec.hold) begin
            dec.valid <= instrValid && legal;
            dec.we    <= instrValid && legal && rdField != '0;   // x0 is never written
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec.op    <= opNext;
            dec.bSel  <= bSelNext;
            dec.rd    <= rdField;
            dec.rs1   <= rs1Next;
            dec.rs2   <= rs2Next;
            dec.imm   <= immNext;
            dec.shamt <= instrWord[RS2_LSB +: SHAMT_W];
        end
    end

endmodule

//--- verilog/hazardScoreboard.sv
`timescale 1ns/10ps

module hazardScoreboard import pipePkg::*; (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  setValid,
    input  logic [REG_ADDR_W-1:0] setRd,
    input  logic                  clrValid,
    input  logic [REG_ADDR_W-1:0] clrRd,
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2,
    output logic                  stall
);

    logic [NUM_REGS-1:0]   busy;
    logic [NUM_REGS-1:0]   setMask;
    logic [NUM_REGS-1:0]   clrMask;
    logic [NUM_REGS-1:0]   busyAfterClr;
    logic                  setLast;     // a writing instruction issued last cycle
    logic [REG_ADDR_W-1:0] setLastRd;   // its rd, now sitting in execute

    always_comb begin
        setMask = '0;
        clrMask = '0;
        if (setValid && setRd != '0) begin
            setMask[setRd] = 1'b1;
        end
        // a younger write to the same rd in execute keeps the bit set
        if (clrValid && clrRd != '0 && !(setLast && setLastRd == clrRd)) begin
            clrMask[clrRd] = 1'b1;
        end
    end

    // the writeback of this cycle already frees its register
    assign busyAfterClr = busy & ~clrMask;

    assign stall = (rs1 != '0 && busyAfterClr[rs1]) ||
                   (rs2 != '0 && busyAfterClr[rs2]);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            busy      <= '0;
            setLast   <= 1'b0;
            setLastRd <= '0;
        end else begin
            busy      <= busyAfterClr | setMask;   // set wins on same rd
            setLast   <= setValid && setRd != '0;
            setLastRd <= setRd;
        end
    end

    // every writeback must belong to an instruction that was issued earlier
    clrOnlyBusy: assert property (@(posedge clk) disable iff (!nrst)
        clrValid && clrRd != '0 |-> busy[clrRd]);

endmodule

//--- verilog/regFile.sv
`timescale 1ns/10ps

module regFile import pipePkg::*; (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] wrAddr,
    input  logic [XLEN-1:0]       wrData,
    input  logic [REG_ADDR_W-1:0] rdAddrA,
    input  logic [REG_ADDR_W-1:0] rdAddrB,
    output logic [XLEN-1:0]       rdDataA,
    output logic [XLEN-1:0]       rdDataB
);

    logic [XLEN-1:0] regs [NUM_REGS];
    logic            wrLive;

    assign wrLive = we && wrAddr != '0;   // x0 writes are dropped

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[wrAddr] <= wrData;
        end
    end

    // write-first, a same-cycle writeback is seen by the reader
    assign rdDataA = (rdAddrA == '0)                 ? '0     :
                     (wrLive && wrAddr == rdAddrA)   ? wrData : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0)                 ? '0     :
                     (wrLive && wrAddr == rdAddrB)   ? wrData : regs[rdAddrB];

endmodule

//--- verilog/stageIf.sv
`timescale 1ns/10ps

// decode -> issue, hold flows back from issue
interface decodeIf import rvIsaPkg::*, pipePkg::*; ();
    logic                  valid;
    aluOp_e                op;
    bSel_e                 bSel;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       imm;      // sign extended, or upper imm for lui
    logic [SHAMT_W-1:0]    shamt;
    logic                  we;
    logic                  hold;     // issue is stalled, keep the word

    modport producer (output valid, op, bSel, rd, rs1, rs2, imm, shamt, we, input hold);
    modport consumer (input valid, op, bSel, rd, rs1, rs2, imm, shamt, we, output hold);
endinterface

// issue -> execute, no back-pressure
interface executeIf import rvIsaPkg::*, pipePkg::*; ();
    logic                  valid;
    aluOp_e                op;
    logic [REG_ADDR_W-1:0] rd;
    logic                  we;
    logic [XLEN-1:0]       opA;
    logic [XLEN-1:0]       opB;

    modport producer (output valid, op, rd, we, opA, opB);
    modport consumer (input valid, op, rd, we, opA, opB);
endinterface

//--- verilog/pipePkg.sv
package pipePkg;

    // datapath width
    localparam int XLEN = 32;

    // width of a fetched instruction word
    localparam int INSTR_W = 32;

    // architectural integer registers, x0 included
    localparam int NUM_REGS = 32;

    localparam int REG_ADDR_W = $clog2(NUM_REGS);   // 5

    // shift amounts only use the low bits of operand b
    localparam int SHAMT_W = $clog2(XLEN);

endpackage

//--- verilog/rvIsaPkg.sv
package rvIsaPkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,   // register-register alu ops
        OP_IMM = 7'b0010011,   // register-immediate alu ops
        LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASSB    // operand b straight through, used by lui
    } aluOp_e;

    // operand b source, picked in issue
    typedef enum logic [1:0] {
        REG,
        IMM,
        SHAMT
    } bSel_e;

    // instruction field positions
    localparam int OPCODE_LSB = 0;
    localparam int OPCODE_W   = 7;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;   // also where the shift amount sits
    localparam int IMM_I_LSB  = 20;
    localparam int IMM_U_LSB  = 12;
    localparam int ALT_BIT    = 30;   // funct7[5], picks sub / sra
    localparam int SIGN_BIT   = 31;

    // funct3 codes of the alu group
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

endpackage
